//--- hw/motorTypesPkg.sv
`default_nettype none

package motorTypesPkg;

    // commutation step code, 0 to 11 while running and 15 when idle
    typedef logic [3:0] stepCode_t;

    // on-time or position amount counted in clock cycles
    typedef logic [15:0] posVal_t;

    // length of one PWM period in clock cycles
    typedef logic [11:0] periodLen_t;

    // length of one commutation step in clock cycles
    typedef logic [24:0] stepTicks_t;

    // the step timer either waits for enable or runs through the steps
    typedef enum logic {
        TIMER_IDLE,
        TIMER_RUN
    } timerState_t;

endpackage

`default_nettype wire

//--- hw/motorStepPkg.sv
`default_nettype none

package motorStepPkg;

    import motorTypesPkg::*;

    // last code of the running sequence, the step after it is code 0 again
    localparam stepCode_t STEP_LAST = 4'd11;

    // held on sgStep while the drive is disabled
    localparam stepCode_t STEP_IDLE = 4'd15;

    // steps in which a phase may not exceed one of its neighbours
    localparam stepCode_t STEP_GATE_B = 4'd6;
    localparam stepCode_t STEP_GATE_C = 4'd11;

    // the lost on-time sum restarts when one of these steps begins,
    // so it always covers one half of the electrical cycle
    localparam stepCode_t STEP_LOST_CLEAR_A = 4'd1;
    localparam stepCode_t STEP_LOST_CLEAR_B = 4'd7;

endpackage

`default_nettype wire

//--- hw/stepTimer.sv
`timescale 1ns/100ps
`default_nettype none

module stepTimer
    import motorTypesPkg::*, motorStepPkg::*;
(
    input  wire logic       clk,
    input  wire logic       rst,
    input  wire logic       enable,
    input  wire stepTicks_t stepLen,
    output stepCode_t       sgStep,
    output logic            stepLast1,
    output logic            stepLast2
);

    timerState_t state;
    stepTicks_t  tickCnt;
    logic        running;
    logic        tickWrap;

    // strobes only fire while the timer runs and is still enabled
    assign running  = (state == TIMER_RUN) && enable;
    assign tickWrap = (tickCnt == stepLen - stepTicks_t'(1));

    // the last two ticks of every step, stepLen of at least 4 keeps them apart
    assign stepLast1 = running && (tickCnt == stepLen - stepTicks_t'(2));
    assign stepLast2 = running && tickWrap;

    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= TIMER_IDLE;
            tickCnt <= '0;
            sgStep  <= STEP_IDLE;
        end else begin
            case (state)
                TIMER_IDLE: begin
                    // the first step starts on the cycle after enable is seen
                    if (enable) begin
                        state   <= TIMER_RUN;
                        tickCnt <= '0;
                        sgStep  <= '0;
                    end
                end
                TIMER_RUN: begin
                    if (!enable) begin
                        state   <= TIMER_IDLE;
                        tickCnt <= '0;
                        sgStep  <= STEP_IDLE;
                    end else if (tickWrap) begin
                        tickCnt <= '0;
                        if (sgStep == STEP_LAST) begin
                            sgStep <= '0;
                        end else begin
                            sgStep <= sgStep + stepCode_t'(1);
                        end
                    end else begin
                        tickCnt <= tickCnt + stepTicks_t'(1);
                    end
                end
                default: begin
                    state   <= TIMER_IDLE;
                    tickCnt <= '0;
                    sgStep  <= STEP_IDLE;
                end
            endcase
        end
    end

    // the phase generators rely on the two strobes being separate cycles
    assert property (@(posedge clk) disable iff (rst)
        !(stepLast1 && stepLast2))
        else $error("stepTimer: stepLast1 and stepLast2 high together");

    // codes 12 to 14 would fall outside the sequence and the idle code
    assert property (@(posedge clk) disable iff (rst)
        !(sgStep inside {[4'd12:4'd14]}))
        else $error("stepTimer: sgStep 0x%h outside the commutation sequence", sgStep);

endmodule

`default_nettype wire

//--- hw/phasePulseGen.sv
`timescale 1ns/100ps
`default_nettype none

module phasePulseGen
    import motorTypesPkg::*, motorStepPkg::*;
#(
    parameter posVal_t minPulse = 16'd256
) (
    input  wire logic       clk,
    input  wire logic       rst,
    input  wire stepCode_t  sgStep,
    input  wire logic       stepLast1,
    input  wire logic       stepLast2,
    input  wire periodLen_t pwmLenWant,
    input  wire posVal_t    plLen,
    input  wire posVal_t    posSumNb1,
    input  wire posVal_t    posSumNb2,
    output posVal_t         posSumOut,
    output logic            pwm,
    output posVal_t         lostAccum
);

    periodLen_t periodCnt;
    logic       idle;
    logic       reload;
    logic       reloadQ;
    logic       periodStart;

    posVal_t    remain;
    posVal_t    candidate;
    logic       minOk;
    logic       loadOk;
    posVal_t    onCnt;

    posVal_t    wantTot;
    posVal_t    realTot;
    posVal_t    wantCap;
    posVal_t    realCap;
    logic       stepEndQ;
    posVal_t    stepLoss;

    assign idle = (sgStep == STEP_IDLE);

    // the period counter is held loaded while the drive is idle, so no pulse
    // is started before the first step
    assign reload = stepLast1 || (periodCnt == periodLen_t'(1)) || (plLen == '0) || idle;

    always_ff @(posedge clk) begin
        if (rst) begin
            periodCnt <= pwmLenWant;
            reloadQ   <= 1'b0;
        end else begin
            reloadQ <= reload;
            if (reload) begin
                periodCnt <= pwmLenWant;
            end else begin
                periodCnt <= periodCnt - periodLen_t'(1);
            end
        end
    end

    // first cycle after a run of load cycles
    assign periodStart = reloadQ && !reload;

    // on-time asked for in this period, including what earlier periods skipped
    assign candidate = remain + plLen;
    assign posSumOut = candidate;
    assign minOk     = (candidate >= minPulse);

    // in the two gated steps a phase may not run longer than its neighbour
    always_comb begin
        case (sgStep)
            STEP_GATE_B: loadOk = minOk && (candidate <= posSumNb1);
            STEP_GATE_C: loadOk = minOk && (candidate <= posSumNb2);
            default:     loadOk = minOk;
        endcase
    end

    // pwm rises with the counter load and drops together with its last count
    always_ff @(posedge clk) begin
        if (rst) begin
            onCnt <= '0;
            pwm   <= 1'b0;
        end else if (periodStart && loadOk) begin
            onCnt <= candidate;
            pwm   <= (candidate != '0);
        end else if (onCnt != '0) begin
            onCnt <= onCnt - posVal_t'(1);
            pwm   <= (onCnt != posVal_t'(1));
        end
    end

    // remainder is cleared on the last tick and refilled one cycle later
    // with whatever the new step could not load
    always_ff @(posedge clk) begin
        if (rst) begin
            stepEndQ <= 1'b0;
            remain   <= '0;
        end else begin
            stepEndQ <= stepLast2;
            if (stepLast2 || idle) begin
                remain <= '0;
            end else if (stepEndQ) begin
                remain <= loadOk ? '0 : candidate;
            end
        end
    end

    // a period starting on the final tick already belongs to the next step,
    // so its request opens the new total instead of closing the old one
    always_ff @(posedge clk) begin
        if (rst) begin
            wantTot <= '0;
            realTot <= '0;
            wantCap <= '0;
            realCap <= '0;
        end else if (idle) begin
            wantTot <= '0;
            realTot <= '0;
        end else if (stepLast2) begin
            wantCap <= wantTot;
            realCap <= realTot + posVal_t'(pwm);
            wantTot <= periodStart ? plLen : '0;
            realTot <= '0;
        end else begin
            if (periodStart) begin
                wantTot <= wantTot + plLen;
            end
            if (pwm) begin
                realTot <= realTot + posVal_t'(1);
            end
        end
    end

    assign stepLoss = wantCap - realCap;

    // sgStep already shows the new step here, so entering step 1 or 7
    // restarts the sum with the step that just ended
    always_ff @(posedge clk) begin
        if (rst) begin
            lostAccum <= '0;
        end else if (stepEndQ) begin
            if (sgStep == STEP_LOST_CLEAR_A || sgStep == STEP_LOST_CLEAR_B) begin
                lostAccum <= stepLoss;
            end else begin
                lostAccum <= lostAccum + stepLoss;
            end
        end
    end

    assert property (@(posedge clk) disable iff (rst)
        (onCnt == '0) |-> !pwm)
        else $error("phasePulseGen: pwm high with an empty on-time counter");

    // outside periodStart the counter may only hold or count down
    assert property (@(posedge clk) disable iff (rst)
        !periodStart |=> (onCnt <= $past(onCnt)))
        else $error("phasePulseGen: on-time counter loaded outside periodStart");

endmodule

`default_nettype wire

//--- hw/motorDriveTop.sv
`timescale 1ns/100ps
`default_nettype none

module motorDriveTop
    import motorTypesPkg::*;
#(
    parameter posVal_t minPulse = 16'd256
) (
    input  wire logic       clk,
    input  wire logic       rst,
    input  wire logic       enable,
    input  wire stepTicks_t stepLen,
    input  wire periodLen_t pwmLenWant,
    input  wire posVal_t    plLenA,
    input  wire posVal_t    plLenB,
    input  wire posVal_t    plLenC,
    output stepCode_t       sgStep,
    output logic            pwmA,
    output logic            pwmB,
    output logic            pwmC,
    output posVal_t         lostA,
    output posVal_t         lostB,
    output posVal_t         lostC
);

    logic    stepLast1;
    logic    stepLast2;

    // candidate on-times shared around the ring of phases
    posVal_t posSumA;
    posVal_t posSumB;
    posVal_t posSumC;

    stepTimer stepTimer_i (
        .clk       (clk),
        .rst       (rst),
        .enable    (enable),
        .stepLen   (stepLen),
        .sgStep    (sgStep),
        .stepLast1 (stepLast1),
        .stepLast2 (stepLast2)
    );

    // each phase sees the next phase as neighbour 1 and the one after as neighbour 2
    phasePulseGen #(.minPulse(minPulse)) phaseA (
        .clk        (clk),
        .rst        (rst),
        .sgStep     (sgStep),
        .stepLast1  (stepLast1),
        .stepLast2  (stepLast2),
        .pwmLenWant (pwmLenWant),
        .plLen      (plLenA),
        .posSumNb1  (posSumB),
        .posSumNb2  (posSumC),
        .posSumOut  (posSumA),
        .pwm        (pwmA),
        .lostAccum  (lostA)
    );

    phasePulseGen #(.minPulse(minPulse)) phaseB (
        .clk        (clk),
        .rst        (rst),
        .sgStep     (sgStep),
        .stepLast1  (stepLast1),
        .stepLast2  (stepLast2),
        .pwmLenWant (pwmLenWant),
        .plLen      (plLenB),
        .posSumNb1  (posSumC),
        .posSumNb2  (posSumA),
        .posSumOut  (posSumB),
        .pwm        (pwmB),
        .lostAccum  (lostB)
    );

    phasePulseGen #(.minPulse(minPulse)) phaseC (
        .clk        (clk),
        .rst        (rst),
        .sgStep     (sgStep),
        .stepLast1  (stepLast1),
        .stepLast2  (stepLast2),
        .pwmLenWant (pwmLenWant),
        .plLen      (plLenC),
        .posSumNb1  (posSumA),
        .posSumNb2  (posSumB),
        .posSumOut  (posSumC),
        .pwm        (pwmC),
        .lostAccum  (lostC)
    );

endmodule

`default_nettype wire

//--- bench/motorDriveTb.sv
`timescale 1ns/100ps
`default_nettype none

module motorDriveTb
    import motorTypesPkg::*, motorStepPkg::*;
();

    localparam int MIN_PULSE = 256;
    localparam int NUM_ROWS  = 5;
    localparam int MAX_PULSES = 64;

    logic       clk = 1'b0;
    logic       rst;
    logic       enable;
    stepTicks_t stepLen;
    periodLen_t pwmLenWant;
    posVal_t    plLenA;
    posVal_t    plLenB;
    posVal_t    plLenC;
    stepCode_t  sgStep;
    logic       pwmA;
    logic       pwmB;
    logic       pwmC;
    posVal_t    lostA;
    posVal_t    lostB;
    posVal_t    lostC;
    logic [2:0] pwmNow;

    // stimulus table with one row per test holding period, on-times, periods per step and steps
    int rowLen[NUM_ROWS];
    int rowPl[NUM_ROWS][3];
    int rowPeriods[NUM_ROWS];
    int rowSteps[NUM_ROWS];
    bit tableReady = 1'b0;

    integer seed;
    int     errors;
    int     rowsFailed;

    // monitor state
    bit         monitorOn = 1'b0;
    stepCode_t  prevCode;
    int         tick;
    bit         firstStep;
    int         stepsDone;
    int         curLen;
    int         curPeriods;
    int         curPl[3];
    int         nRise[3];
    int         riseT[3][MAX_PULSES];
    int         widthV[3][MAX_PULSES];
    int         startT[3];
    int         highTot[3];
    int         stepLoss[3];
    int         expLost[3];
    bit         lostPending;
    logic [2:0] pwmPrev;

    motorDriveTop #(.minPulse(posVal_t'(MIN_PULSE))) motorDriveTop_i (
        .clk        (clk),
        .rst        (rst),
        .enable     (enable),
        .stepLen    (stepLen),
        .pwmLenWant (pwmLenWant),
        .plLenA     (plLenA),
        .plLenB     (plLenB),
        .plLenC     (plLenC),
        .sgStep     (sgStep),
        .pwmA       (pwmA),
        .pwmB       (pwmB),
        .pwmC       (pwmC),
        .lostA      (lostA),
        .lostB      (lostB),
        .lostC      (lostC)
    );

    assign pwmNow = {pwmC, pwmB, pwmA};

    always #4 clk = ~clk;

    function automatic string phaseName(input int p);
        return (p == 0) ? "A" : ((p == 1) ? "B" : "C");
    endfunction

    function automatic int lostOf(input int p);
        return (p == 0) ? int'(lostA) : ((p == 1) ? int'(lostB) : int'(lostC));
    endfunction

    function automatic int nextCode(input int code);
        return (code == 11) ? 0 : code + 1;
    endfunction

    // a phase may not exceed its next neighbour in step 6 and the one after in step 11
    function automatic bit neighbourGated(input int p, input int code);
        if (code == 6 && curPl[p] > curPl[(p + 1) % 3]) begin
            return 1'b1;
        end
        if (code == 11 && curPl[p] > curPl[(p + 2) % 3]) begin
            return 1'b1;
        end
        return 1'b0;
    endfunction

    task automatic reportMismatch(input string what, input int got, input int expected);
        $display("[FAIL] %s: got 0x%0h expected 0x%0h", what, got, expected);
        errors++;
    endtask

    // the first period of a step is decided on the last tick of the step before,
    // except right after enable where the first step decides its own
    task automatic checkStep(input int code);
        int p;
        int k;
        int n;
        int d;
        int expRise;
        for (p = 0; p < 3; p++) begin
            n = 0;
            for (k = 0; k < curPeriods; k++) begin
                d = (k == 0 && !firstStep) ? ((code == 0) ? 11 : code - 1) : code;
                if (curPl[p] >= MIN_PULSE && !neighbourGated(p, d)) begin
                    expRise = k * curLen + (firstStep ? 1 : 0);
                    if (n < nRise[p] && n < MAX_PULSES) begin
                        if (riseT[p][n] != expRise) begin
                            reportMismatch($sformatf("pwm%s rise tick, step %0d pulse %0d",
                                phaseName(p), code, n), riseT[p][n], expRise);
                        end
                        if (widthV[p][n] != curPl[p]) begin
                            reportMismatch($sformatf("pwm%s width, step %0d pulse %0d",
                                phaseName(p), code, n), widthV[p][n], curPl[p]);
                        end
                    end
                    n++;
                end
            end
            if (nRise[p] != n) begin
                reportMismatch($sformatf("pwm%s pulse count, step %0d", phaseName(p), code),
                    nRise[p], n);
            end
            if (highTot[p] != n * curPl[p]) begin
                reportMismatch($sformatf("pwm%s high cycles, step %0d", phaseName(p), code),
                    highTot[p], n * curPl[p]);
            end
            stepLoss[p] = (curPeriods - n) * curPl[p];
        end
    endtask

    // outputs are sampled on the falling edge half a cycle after they change
    always @(negedge clk) begin
        if (monitorOn) begin
            if (sgStep != prevCode) begin
                if (sgStep != STEP_IDLE) begin
                    if (prevCode != STEP_IDLE) begin
                        if (tick + 1 != curLen * curPeriods) begin
                            reportMismatch($sformatf("step %0d length", prevCode),
                                tick + 1, curLen * curPeriods);
                        end
                        if (int'(sgStep) != nextCode(int'(prevCode))) begin
                            reportMismatch("sgStep", int'(sgStep), nextCode(int'(prevCode)));
                        end
                        checkStep(int'(prevCode));
                        for (int p = 0; p < 3; p++) begin
                            if (sgStep == STEP_LOST_CLEAR_A || sgStep == STEP_LOST_CLEAR_B) begin
                                expLost[p] = stepLoss[p] & 16'hffff;
                            end else begin
                                expLost[p] = (expLost[p] + stepLoss[p]) & 16'hffff;
                            end
                        end
                        lostPending = 1'b1;
                        stepsDone++;
                    end else if (sgStep != 4'd0) begin
                        reportMismatch("sgStep after enable", int'(sgStep), 0);
                    end
                    firstStep = (prevCode == STEP_IDLE);
                    for (int p = 0; p < 3; p++) begin
                        nRise[p] = 0;
                        highTot[p] = 0;
                    end
                end
                tick = 0;
                prevCode = sgStep;
            end else begin
                tick++;
            end

            // lostAccum settles one cycle after the step end
            if (lostPending && tick == 1) begin
                for (int p = 0; p < 3; p++) begin
                    if (lostOf(p) != expLost[p]) begin
                        reportMismatch($sformatf("lost%s", phaseName(p)), lostOf(p), expLost[p]);
                    end
                end
                lostPending = 1'b0;
            end

            for (int p = 0; p < 3; p++) begin
                if (pwmNow[p] && !pwmPrev[p]) begin
                    if (nRise[p] < MAX_PULSES) begin
                        riseT[p][nRise[p]] = tick;
                        widthV[p][nRise[p]] = 0;
                    end
                    startT[p] = tick;
                    nRise[p]++;
                end
                if (!pwmNow[p] && pwmPrev[p]) begin
                    if (nRise[p] > 0 && nRise[p] <= MAX_PULSES) begin
                        widthV[p][nRise[p] - 1] = tick - startT[p];
                    end
                end
                if (pwmNow[p]) begin
                    highTot[p]++;
                end
            end
            pwmPrev = pwmNow;
        end
    end

    task automatic buildTable();
        int r;
        int p;
        int rnd;
        rowLen[0] = 400;
        rowPl[0] = '{300, 300, 300};
        rowPeriods[0] = 3;
        rowSteps[0] = 14;
        // phase A stays below the minimum while B and C meet the gate in steps 6 and 11
        rowLen[1] = 500;
        rowPl[1] = '{100, 400, 350};
        rowPeriods[1] = 2;
        rowSteps[1] = 14;
        rowLen[2] = 600;
        rowPl[2] = '{450, 300, 300};
        rowPeriods[2] = 2;
        rowSteps[2] = 13;
        for (r = 3; r < NUM_ROWS; r++) begin
            rowLen[r] = 512;
            rowPeriods[r] = 2;
            rowSteps[r] = 13;
            for (p = 0; p < 3; p++) begin
                rnd = $random(seed);
                rnd = rnd & 32'h7fffffff;
                rowPl[r][p] = MIN_PULSE + rnd % (rowLen[r] - 2 - MIN_PULSE + 1);
            end
        end
    endtask

    task automatic checkIdle();
        if (sgStep != STEP_IDLE) begin
            reportMismatch("sgStep after reset", int'(sgStep), 15);
        end
        if (pwmNow != 3'b000) begin
            reportMismatch("pwmC/pwmB/pwmA after reset", int'(pwmNow), 0);
        end
        for (int p = 0; p < 3; p++) begin
            if (lostOf(p) != 0) begin
                reportMismatch($sformatf("lost%s after reset", phaseName(p)), lostOf(p), 0);
            end
        end
    endtask

    task automatic runRow(input int r);
        int errBefore;
        errBefore = errors;
        @(negedge clk);
        enable = 1'b0;
        pwmLenWant = periodLen_t'(rowLen[r]);
        stepLen = stepTicks_t'(rowLen[r] * rowPeriods[r]);
        plLenA = posVal_t'(rowPl[r][0]);
        plLenB = posVal_t'(rowPl[r][1]);
        plLenC = posVal_t'(rowPl[r][2]);
        curLen = rowLen[r];
        curPeriods = rowPeriods[r];
        for (int p = 0; p < 3; p++) begin
            curPl[p] = rowPl[r][p];
        end
        repeat (8) @(negedge clk);
        stepsDone = 0;
        enable = 1'b1;
        while (stepsDone < rowSteps[r]) begin
            @(negedge clk);
        end
        repeat (3) @(negedge clk);
        enable = 1'b0;
        // let a pulse that is still running drain before the next row
        repeat (rowLen[r] + 16) @(negedge clk);
        if (errors != errBefore) begin
            rowsFailed++;
        end
        $display("row %0d: period %0d, plLen %0d/%0d/%0d, %0d steps, %0d errors", r,
            rowLen[r], rowPl[r][0], rowPl[r][1], rowPl[r][2], rowSteps[r], errors - errBefore);
    endtask

    initial begin
        seed = 21391;
        errors = 0;
        rowsFailed = 0;
        rst = 1'b1;
        enable = 1'b0;
        stepLen = '0;
        pwmLenWant = periodLen_t'(400);
        plLenA = '0;
        plLenB = '0;
        plLenC = '0;
        pwmPrev = 3'b000;
        lostPending = 1'b0;
        buildTable();
        tableReady = 1'b1;
        repeat (10) @(negedge clk);
        rst = 1'b0;
        repeat (2) @(negedge clk);
        checkIdle();
        prevCode = STEP_IDLE;
        tick = 0;
        monitorOn = 1'b1;
        for (int r = 0; r < NUM_ROWS; r++) begin
            runRow(r);
        end
        $display("rows run %0d, rows failed %0d, errors %0d", NUM_ROWS, rowsFailed, errors);
        if (errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

    // watchdog sized from the table
    initial begin
        int limit;
        wait (tableReady);
        limit = 0;
        for (int r = 0; r < NUM_ROWS; r++) begin
            limit += rowLen[r] * rowPeriods[r] * rowSteps[r] + 2 * rowLen[r] + 40;
        end
        limit = limit * 2 + 1000;
        repeat (limit) @(posedge clk);
        $display("timeout: the run did not finish within %0d cycles", limit);
        $display("SOME TESTS FAILED");
        $finish;
    end

endmodule

`default_nettype wire

//--- tb.f
hw/motorTypesPkg.sv
hw/motorStepPkg.sv
hw/stepTimer.sv
hw/phasePulseGen.sv
hw/motorDriveTop.sv
bench/motorDriveTb.sv

//--- Makefile
# Verilator build and run for the motor drive testbench

VERILATOR ?= verilator
TOP       ?= motorDriveTb
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
JOBS      ?= 0
VFLAGS    ?= --binary --timing --assert -j $(JOBS)

SRCS := $(shell grep -v '^+' $(FILELIST))
SIM  := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM)

$(SIM): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# the log decides pass or fail, a missing pass line also counts as failure
run: $(SIM)
	./$(SIM) | tee $(LOG)
	@if grep -q "SOME TESTS FAILED" $(LOG); then \
		echo "simulation failed"; exit 1; \
	fi
	@grep -q "ALL TESTS PASSED" $(LOG) || { echo "no pass line in $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)
